// ==== build.f ====
hdl/branchPredPkg.sv
hdl/predRam.sv
hdl/btb.sv
hdl/directionPredictor.sv
hdl/nextPcSelect.sv
hdl/branchPredictor.sv
verification/branchPredictorTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module branchPredictorTb -f build.f -o simv \
  > build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "^RESULT: PASS$" sim.log && exit 0 || exit 1

// ==== verification/predictorPatterns.txt ====
# stall updEn updPc updTarget updClass updTaken pcNext check expPredPc expPredClass expPredTaken
# All hex, expected values are the prediction for the previous unstalled line's pcNext
# Reset and untrained lookups
0 0 00000000 00000000 0 0 00002000 1 00000004 0 0
0 0 00000000 00000000 0 0 00002100 1 00002004 0 0
# Jump and return
0 1 00001040 00001800 2 1 00002200 1 00002104 0 0
0 1 00001084 00001200 8 1 00001040 1 00002204 0 0
0 0 00000000 00000000 0 0 00001084 1 00001800 2 1
0 0 00000000 00000000 0 0 00002000 1 00001200 8 1
# Branch training, counter starts at 1
0 1 00001108 00001400 1 1 00002000 1 00002004 0 0
0 1 00001108 00001400 1 1 00001108 1 00002004 0 0
0 1 00001108 00001400 1 1 00001108 1 00001400 1 1
0 1 00001108 00001400 1 0 00001108 1 00001400 1 1
0 1 00001108 00001400 1 0 00001108 1 00001400 1 1
0 0 00000000 00000000 0 0 00002000 1 0000110c 1 0
# Same-cycle bypass, jalr then branch
0 1 00001234 00003000 4 1 00001234 1 00002004 0 0
0 1 00001310 00001500 1 1 00001310 1 00003000 4 1
0 0 00000000 00000000 0 0 00002000 1 00001500 1 1
# Aliasing through the bit-1 fold and clearing
0 1 00001050 00002100 2 1 00002000 1 00002004 0 0
0 0 00000000 00000000 0 0 00001050 1 00002004 0 0
0 1 000010d2 00002200 2 1 00002000 1 00002100 2 1
0 0 00000000 00000000 0 0 00001050 1 00002004 0 0
0 0 00000000 00000000 0 0 000010d2 1 00002200 2 1
0 1 000010d2 00000000 0 0 00002000 1 00002200 2 1
0 0 00000000 00000000 0 0 000010d2 1 00002004 0 0
0 0 00000000 00000000 0 0 00001050 1 000010d6 0 0
0 0 00000000 00000000 0 0 00002000 1 00001054 0 0
# Stall holds the prediction while pcNext moves and an update lands
0 0 00000000 00000000 0 0 00001040 1 00002004 0 0
1 1 00001040 00001900 2 1 00001084 1 00001800 2 1
1 0 00000000 00000000 0 0 00001234 1 00001800 2 1
0 0 00000000 00000000 0 0 00001040 1 00001800 2 1
0 0 00000000 00000000 0 0 00002000 1 00001900 2 1
0 0 00000000 00000000 0 0 00002000 1 00002004 0 0

// ==== verification/branchPredictorTb.sv ====
`timescale 1ns/100ps

module branchPredictorTb;

  import branchPredPkg::*;

  // One line of the pattern file
  typedef struct packed {
    logic       stall;
    logic       updateEn;
    updateT     update;
    addrT       pcNext;
    logic       check;
    predictionT expected;
  } patternT;

  localparam string PatternFile = "verification/predictorPatterns.txt";

  logic       clk;
  logic       reset;
  addrT       pcNext;
  logic       stall;
  updateT     update;
  logic       updateEn;
  predictionT prediction;

  patternT patterns[$];
  int      errors = 0;
  int      checks = 0;
  int      cycles = 0;
  int      cycleLimit = 0;

  branchPredictor #(
    .IndexBits (6)
  ) branchPredictor_inst (
    .clk        (clk),
    .reset      (reset),
    .pcNext     (pcNext),
    .stall      (stall),
    .update     (update),
    .updateEn   (updateEn),
    .prediction (prediction)
  );

  ////////////////////
  // Clock and watchdog
  ////////////////////

  // 4 ns period
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Limit is known once the pattern file is loaded
  initial begin
    wait (cycleLimit > 0);
    while (cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Error: simulation timed out after %0d cycles", cycles);
    $display("Checks run: %0d, errors: %0d", checks, errors + 1);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Parse every data line of the pattern file into the queue
  task automatic loadPatterns();
    int          fd;
    int          count;
    string       line;
    logic [31:0] fStall, fUpdEn, fUpdPc, fUpdTarget, fUpdClass, fUpdTaken;
    logic [31:0] fPcNext, fCheck, fExpPc, fExpClass, fExpTaken;
    patternT     p;
    fd = $fopen(PatternFile, "r");
    if (fd == 0) begin
      errors++;
      $display("Error: could not open pattern file %s", PatternFile);
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // Comment lines
      if (line.getc(0) == "#") continue;
      count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", fStall, fUpdEn, fUpdPc,
                      fUpdTarget, fUpdClass, fUpdTaken, fPcNext, fCheck, fExpPc,
                      fExpClass, fExpTaken);
      if (count <= 0) continue;
      if (count != 11) begin
        errors++;
        $display("Error: malformed pattern line: %s", line);
        continue;
      end
      p.stall              = fStall[0];
      p.updateEn           = fUpdEn[0];
      p.update.pc          = fUpdPc;
      p.update.target      = fUpdTarget;
      p.update.instrClass  = fUpdClass[3:0];
      p.update.taken       = fUpdTaken[0];
      p.pcNext             = fPcNext;
      p.check              = fCheck[0];
      p.expected.predPc    = fExpPc;
      p.expected.predClass = fExpClass[3:0];
      p.expected.predTaken = fExpTaken[0];
      patterns.push_back(p);
    end
    $fclose(fd);
  endtask

  // Inputs change just after the edge
  task automatic applyPattern(input patternT p);
    stall    <= p.stall;
    updateEn <= p.updateEn;
    update   <= p.update;
    pcNext   <= p.pcNext;
  endtask

  // Compare each prediction field against the pattern
  task automatic checkPrediction(input predictionT exp, input int idx);
    checks++;
    if (prediction.predPc !== exp.predPc) begin
      errors++;
      $display("Error: predPc expected %h got %h at pattern %0d",
               exp.predPc, prediction.predPc, idx);
    end
    if (prediction.predClass !== exp.predClass) begin
      errors++;
      $display("Error: predClass expected %h got %h at pattern %0d",
               exp.predClass, prediction.predClass, idx);
    end
    if (prediction.predTaken !== exp.predTaken) begin
      errors++;
      $display("Error: predTaken expected %h got %h at pattern %0d",
               exp.predTaken, prediction.predTaken, idx);
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    patternT pending;
    logic    havePending;
    int      pendingIdx;
    reset       = 1'b1;
    stall       = 1'b0;
    updateEn    = 1'b0;
    update      = '0;
    pcNext      = '0;
    havePending = 1'b0;
    pendingIdx  = 0;
    pending     = '0;
    loadPatterns();
    cycleLimit = 4 * patterns.size() + 20;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    // Prediction seen at an edge belongs to the line driven one edge before
    for (int i = 0; i < patterns.size(); i++) begin
      @(posedge clk);
      if (havePending && pending.check) begin
        checkPrediction(pending.expected, pendingIdx);
      end
      applyPattern(patterns[i]);
      pending     = patterns[i];
      pendingIdx  = i;
      havePending = 1'b1;
    end
    // Last line still owes its check
    @(posedge clk);
    if (havePending && pending.check) begin
      checkPrediction(pending.expected, pendingIdx);
    end
    if (checks == 0) begin
      errors++;
      $display("Error: no pattern was checked");
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== hdl/branchPredictor.sv ====
`timescale 1ns/100ps

module branchPredictor #(
  parameter int IndexBits = branchPredPkg::indexBits
) (
  input  logic                      clk,
  input  logic                      reset,
  input  branchPredPkg::addrT       pcNext,
  input  logic                      stall,
  input  branchPredPkg::updateT     update,
  input  logic                      updateEn,
  output branchPredPkg::predictionT prediction
);

  import branchPredPkg::*;

  logic     hit;
  btbEntryT entry;
  counterT  counter;

  // Target and class lookup
  btb #(
    .IndexBits (IndexBits)
  ) btb_inst (
    .clk      (clk),
    .reset    (reset),
    .pcNext   (pcNext),
    .stall    (stall),
    .update   (update),
    .updateEn (updateEn),
    .hit      (hit),
    .entry    (entry)
  );

  // Taken / not taken lookup in parallel
  directionPredictor #(
    .IndexBits (IndexBits)
  ) directionPredictor_inst (
    .clk      (clk),
    .reset    (reset),
    .pcNext   (pcNext),
    .stall    (stall),
    .update   (update),
    .updateEn (updateEn),
    .counter  (counter)
  );

  // Merge both into the next PC
  nextPcSelect nextPcSelect_inst (
    .clk        (clk),
    .reset      (reset),
    .pcNext     (pcNext),
    .stall      (stall),
    .hit        (hit),
    .entry      (entry),
    .counter    (counter),
    .prediction (prediction)
  );

endmodule

// ==== hdl/nextPcSelect.sv ====
`timescale 1ns/100ps

module nextPcSelect (
  input  logic                      clk,
  input  logic                      reset,
  input  branchPredPkg::addrT       pcNext,
  input  logic                      stall,
  input  logic                      hit,
  input  branchPredPkg::btbEntryT   entry,
  input  branchPredPkg::counterT    counter,
  output branchPredPkg::predictionT prediction
);

  import branchPredPkg::*;

  addrT fetchPc;
  addrT seqPc;
  logic isBranch;
  logic isUncond;
  logic taken;

  // Fetch PC tracks the lookup registers in btb
  always_ff @(posedge clk) begin
    if (reset) begin
      fetchPc <= '0;
    end else if (~stall) begin
      fetchPc <= pcNext;
    end
  end

  assign seqPc = fetchPc + addrT'(4);

  // Class decode of the stored entry
  assign isBranch = entry.instrClass[classBranch];
  // jump, jalr and return always redirect
  assign isUncond = entry.instrClass[classJump] | entry.instrClass[classJalr] |
                    entry.instrClass[classReturn];

  // Conditional branches follow the counter msb
  assign taken = hit & (isUncond | (isBranch & counter[1]));

  assign prediction.predTaken = taken;
  assign prediction.predClass = hit ? entry.instrClass : '0;
  assign prediction.predPc    = taken ? entry.target : seqPc;

  // Stall freezes every lookup register feeding this block
  predictionHeldOnStall: assert property (
    @(posedge clk) disable iff (reset)
    stall |=> $stable(prediction)
  ) else $error("nextPcSelect: prediction changed during stall");

endmodule

// ==== hdl/directionPredictor.sv ====
`timescale 1ns/100ps

module directionPredictor #(
  parameter int IndexBits = 6
) (
  input  logic                   clk,
  input  logic                   reset,
  input  branchPredPkg::addrT    pcNext,
  input  logic                   stall,
  input  branchPredPkg::updateT  update,
  input  logic                   updateEn,
  output branchPredPkg::counterT counter
);

  import branchPredPkg::*;

  localparam int Depth = 1 << IndexBits;

  counterT              counters [Depth];
  logic [IndexBits-1:0] lookupIdx;
  logic [IndexBits-1:0] updIdx;
  logic                 train;
  counterT              oldCtr;
  counterT              newCtr;
  counterT              counterNext;

  // Same index hash as the target buffer
  function automatic logic [IndexBits-1:0] hashPc(input addrT pc);
    hashPc = {pc[IndexBits+1] ^ pc[1], pc[IndexBits:2]};
  endfunction

  assign lookupIdx = reset ? '0 : hashPc(pcNext);
  assign updIdx    = hashPc(update.pc);

  // Only resolved conditional branches train
  assign train = updateEn & update.instrClass[classBranch];

  ////////////////////
  // Saturating update
  ////////////////////

  assign oldCtr = counters[updIdx];

  always_comb begin
    newCtr = oldCtr;
    if (update.taken) begin
      if (oldCtr != 2'd3) newCtr = oldCtr + 2'd1;
    end else begin
      if (oldCtr != 2'd0) newCtr = oldCtr - 2'd1;
    end
  end

  // Counter table, all weakly not taken out of reset
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < Depth; i++) begin
        counters[i] <= 2'd1;
      end
    end else if (train) begin
      counters[updIdx] <= newCtr;
    end
  end

  // Registered lookup, trained value wins on a collision
  assign counterNext = (train && (updIdx == lookupIdx)) ? newCtr : counters[lookupIdx];

  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= 2'd1;
    end else if (~stall) begin
      counter <= counterNext;
    end
  end

  // Stored counter moves toward the outcome and never wraps around
  counterNoWrap: assert property (
    @(posedge clk) disable iff (reset)
    train |=> ($past(update.taken) ? (counters[$past(updIdx)] >= $past(oldCtr))
                                   : (counters[$past(updIdx)] <= $past(oldCtr)))
  ) else $error("directionPredictor: counter wrapped");

endmodule

// ==== hdl/btb.sv ====
`timescale 1ns/100ps

module btb #(
  parameter int IndexBits = 6
) (
  input  logic                  clk,
  input  logic                  reset,
  input  branchPredPkg::addrT   pcNext,
  input  logic                  stall,
  input  branchPredPkg::updateT update,
  input  logic                  updateEn,
  output logic                  hit,
  output branchPredPkg::btbEntryT entry
);

  import branchPredPkg::*;

  localparam int Depth = 1 << IndexBits;

  logic [IndexBits-1:0] lookupIdx;
  logic [IndexBits-1:0] updIdx;
  logic [Depth-1:0]     validBits;
  logic                 readEn;
  logic                 writeEn;
  logic                 idxMatch;
  logic                 validNext;
  logic                 bypassSel;
  btbEntryT             writeEntry;
  btbEntryT             bypassEntry;
  btbEntryT             ramEntry;

  // Index hash
  // Bit 1 is only nonzero with compressed code, so fold it into the top bit
  function automatic logic [IndexBits-1:0] hashPc(input addrT pc);
    hashPc = {pc[IndexBits+1] ^ pc[1], pc[IndexBits:2]};
  endfunction

  ////////////////////
  // Lookup side
  ////////////////////

  // pcNext is not defined in reset, so park the lookup on entry 0
  assign lookupIdx = reset ? '0 : hashPc(pcNext);
  assign readEn    = ~stall | reset;

  ////////////////////
  // Update side
  ////////////////////

  assign updIdx     = hashPc(update.pc);
  assign writeEn    = updateEn & (|update.instrClass);
  assign writeEntry = '{instrClass: update.instrClass, target: update.target};

  // Valid bits live in flops so reset clears the whole table at once
  // A zero class from execute means the entry was wrongly taken as control
  always_ff @(posedge clk) begin
    if (reset) begin
      validBits <= '0;
    end else if (updateEn) begin
      validBits[updIdx] <= |update.instrClass;
    end
  end

  // Entry payload
  predRam #(
    .Depth (Depth),
    .Width ($bits(btbEntryT))
  ) entryRam (
    .clk       (clk),
    .readEn    (readEn),
    .readAddr  (lookupIdx),
    .readData  (ramEntry),
    .writeEn   (writeEn),
    .writeAddr (updIdx),
    .writeData (writeEntry)
  );

  ////////////////////
  // Same-cycle bypass
  ////////////////////

  assign idxMatch = updIdx == lookupIdx;

  // Valid bit seen by this lookup, new value wins on a collision
  assign validNext = (updateEn & idxMatch) ? (|update.instrClass) : validBits[lookupIdx];

  always_ff @(posedge clk) begin
    if (reset) begin
      hit       <= 1'b0;
      bypassSel <= 1'b0;
    end else if (readEn) begin
      hit       <= validNext;
      bypassSel <= writeEn & idxMatch;
    end
  end

  // Copy of the written entry for the collision case
  always_ff @(posedge clk) begin
    if (readEn) begin
      bypassEntry <= writeEntry;
    end
  end

  // RAM returns stale data on a collision, so pick the captured copy
  assign entry = bypassSel ? bypassEntry : ramEntry;

  // Execute must hand over a clean class encoding
  updateClassOneHot: assert property (
    @(posedge clk) disable iff (reset)
    updateEn |-> $onehot0(update.instrClass)
  ) else $error("btb: update class is not one-hot");

endmodule

// ==== hdl/predRam.sv ====
`timescale 1ns/100ps

module predRam #(
  parameter int Depth = 64,
  parameter int Width = 36
) (
  input  logic                     clk,
  input  logic                     readEn,
  input  logic [$clog2(Depth)-1:0] readAddr,
  output logic [Width-1:0]         readData,
  input  logic                     writeEn,
  input  logic [$clog2(Depth)-1:0] writeAddr,
  input  logic [Width-1:0]         writeData
);

  // Storage array, contents undefined until written
  logic [Width-1:0] mem [Depth];

  // Synchronous write port
  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[writeAddr] <= writeData;
    end
  end

  // Registered read, holds its value while readEn is low
  // Old data is returned on a read/write collision
  always_ff @(posedge clk) begin
    if (readEn) begin
      readData <= mem[readAddr];
    end
  end

endmodule

// ==== hdl/branchPredPkg.sv ====
package branchPredPkg;

  ////////////////////
  // Widths
  ////////////////////

  // Address width of the core
  localparam int xlen = 32;
  // Default table index width, 64 entries
  localparam int indexBits = 6;

  // PC or target address
  typedef logic [xlen-1:0] addrT;
  // One-hot instruction class, all zeros for a non-control instruction
  typedef logic [3:0] instrClassT;
  // Two-bit saturating counter value
  typedef logic [1:0] counterT;

  // Bit positions inside instrClassT
  localparam int classBranch = 0;
  localparam int classJump   = 1;
  localparam int classJalr   = 2;
  localparam int classReturn = 3;

  ////////////////////
  // Structs
  ////////////////////

  // Payload of one target buffer entry
  typedef struct packed {
    instrClassT instrClass;
    addrT       target;
  } btbEntryT;

  // Resolved control flow info from execute
  typedef struct packed {
    addrT       pc;
    addrT       target;
    instrClassT instrClass;
    logic       taken;
  } updateT;

  // Final prediction handed to fetch
  typedef struct packed {
    addrT       predPc;
    instrClassT predClass;
    logic       predTaken;
  } predictionT;

endpackage
